//--- rtl/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// Sprites kept per line
	parameter int MAX_SPRITES = 10;

	parameter int OAM_ENTRIES = 40;

	// Sprite heights in rows
	parameter int SPRITE_H      = 8;
	parameter int SPRITE_H_TALL = 16;

	// Screen coordinate, used for line, Y, X and the pixel counter
	typedef logic [7:0] coord_t;

	typedef logic [5:0] oam_index_t;

	// Slot number, ten slots fit in four bits
	typedef logic [3:0] slot_t;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		FULL
	} scan_state_t;

endpackage

`default_nettype wire

//--- rtl/sprite_load_if.sv
`default_nettype none

interface sprite_load_if #(
	parameter int MAX_SPRITES = sprite_pkg::MAX_SPRITES
) (
	input wire logic clk
);
	import sprite_pkg::*;

	logic       load;
	slot_t      slot;
	coord_t     x;
	oam_index_t index;

	modport source (
		output load, slot, x, index
	);

	modport sink (
		input load, slot, x, index
	);

	// The scanner never hands out a slot past the end of the store
	a_slot_range: assert property (@(posedge clk) load |-> (slot < MAX_SPRITES));

endinterface

`default_nettype wire

//--- rtl/oam_scan.sv
`default_nettype none

module oam_scan #(
	parameter int MAX_SPRITES = sprite_pkg::MAX_SPRITES
) (
	input wire                   clk,
	input wire                   rst_n,
	input wire                   line_start,
	input wire sprite_pkg::coord_t line,
	input wire                   tall,
	input wire                   entry_valid,
	input wire sprite_pkg::coord_t entry_y,
	input wire sprite_pkg::coord_t entry_x,
	sprite_load_if.source        load
);
	import sprite_pkg::*;

	scan_state_t state;
	slot_t       slot_cnt;
	oam_index_t  idx_cnt;

	logic [8:0] y_end;
	logic       on_line;
	logic       take;
	logic       last_slot;
	logic       last_entry;

	// One past the bottom row, nine bits so Y near 255 does not wrap
	assign y_end = {1'b0, entry_y} + (tall ? 9'(SPRITE_H_TALL) : 9'(SPRITE_H));

	assign on_line = (line >= entry_y) && ({1'b0, line} < y_end);

	assign take       = entry_valid && on_line && (state == SCAN) && !line_start;
	assign last_slot  = (slot_cnt == slot_t'(MAX_SPRITES - 1));
	assign last_entry = (idx_cnt == oam_index_t'(OAM_ENTRIES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			slot_cnt <= '0;
			idx_cnt  <= '0;
		end else if (line_start) begin
			state    <= SCAN;
			slot_cnt <= '0;
			idx_cnt  <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					state <= IDLE;
				end
				SCAN: begin
					if (entry_valid) begin
						idx_cnt <= idx_cnt + 1'b1;
						if (take && last_slot)
							state <= FULL;
						else if (last_entry)
							state <= IDLE; // Whole OAM seen
					end
					if (take)
						slot_cnt <= slot_cnt + 1'b1;
				end
				FULL: begin
					state <= FULL; // Held until the next line
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Written into the store at the edge that ends the entry cycle
	assign load.load  = take;
	assign load.slot  = slot_cnt;
	assign load.x     = entry_x;
	assign load.index = idx_cnt;

	a_no_load_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == FULL) |-> !load.load
	);

endmodule

`default_nettype wire

//--- rtl/sprite_x_store.sv
`default_nettype none

module sprite_x_store #(
	parameter int MAX_SPRITES = sprite_pkg::MAX_SPRITES
) (
	input wire                      clk,
	input wire                      rst_n,
	input wire                      line_start,
	input wire sprite_pkg::coord_t  pix_x,
	input wire                      clear,
	input wire sprite_pkg::slot_t   clear_slot,
	sprite_load_if.sink             load,
	output logic [MAX_SPRITES-1:0]  match,
	output sprite_pkg::oam_index_t  index_array [MAX_SPRITES]
);
	import sprite_pkg::*;

	logic [MAX_SPRITES-1:0] valid;
	logic [MAX_SPRITES-1:0] wr_sel;
	logic [MAX_SPRITES-1:0] clr_sel;

	coord_t     x_q   [MAX_SPRITES];
	oam_index_t idx_q [MAX_SPRITES];

	// One-hot decode of the write and clear slot numbers
	always_comb begin
		wr_sel  = '0;
		clr_sel = '0;
		for (int i = 0; i < MAX_SPRITES; i++) begin
			wr_sel[i]  = load.load && (load.slot == slot_t'(i));
			clr_sel[i] = clear && (clear_slot == slot_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid <= '0;
		else if (line_start)
			valid <= '0; // New line drops every sprite
		else
			valid <= (valid & ~clr_sel) | wr_sel;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < MAX_SPRITES; i++) begin
			if (wr_sel[i]) begin
				x_q[i]   <= load.x;
				idx_q[i] <= load.index;
			end
		end
	end

	// All slots compared against the pixel counter at once
	for (genvar i = 0; i < MAX_SPRITES; i++) begin : g_cmp
		assign match[i]       = valid[i] && (x_q[i] == pix_x);
		assign index_array[i] = idx_q[i];
	end

	// A fetch only ever retires a sprite that is still held
	a_clear_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		clear |-> (clear_slot < MAX_SPRITES) && valid[clear_slot]
	);

	a_no_load_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(load.load && clear && (load.slot == clear_slot))
	);

endmodule

`default_nettype wire

//--- rtl/sprite_fetch_select.sv
`default_nettype none

module sprite_fetch_select #(
	parameter int MAX_SPRITES = sprite_pkg::MAX_SPRITES
) (
	input wire                      clk,
	input wire                      rst_n,
	input wire [MAX_SPRITES-1:0]    match,
	input wire sprite_pkg::oam_index_t index_array [MAX_SPRITES],
	input wire                      fetch_ready,
	output logic                    stall,
	output logic                    fetch_valid,
	output sprite_pkg::slot_t       fetch_slot,
	output sprite_pkg::oam_index_t  fetch_index,
	output logic                    clear,
	output sprite_pkg::slot_t       clear_slot
);
	import sprite_pkg::*;

	slot_t sel;
	logic  xfer;

	// Lowest matching slot wins
	always_comb begin
		sel = '0;
		for (int i = MAX_SPRITES - 1; i >= 0; i--) begin
			if (match[i])
				sel = slot_t'(i);
		end
	end

	assign xfer = fetch_valid && fetch_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			fetch_valid <= 1'b0;
		else if (!fetch_valid)
			fetch_valid <= |match;
		else if (fetch_ready)
			fetch_valid <= 1'b0; // Next match waits one cycle for the clear
	end

	// Request payload only loads while idle, so it holds until the transfer
	always_ff @(posedge clk) begin
		if (!fetch_valid && (|match)) begin
			fetch_slot  <= sel;
			fetch_index <= index_array[sel];
		end
	end

	assign clear      = xfer;
	assign clear_slot = fetch_slot;

	// Pixel counter waits on a pending match or an open request
	assign stall = (|match) || fetch_valid;

	a_hold_payload: assert property (
		@(posedge clk) disable iff (!rst_n)
		(fetch_valid && !fetch_ready) |=>
			fetch_valid && $stable(fetch_slot) && $stable(fetch_index)
	);

endmodule

`default_nettype wire

//--- rtl/sprite_line_top.sv
`default_nettype none

module sprite_line_top #(
	parameter int MAX_SPRITES = sprite_pkg::MAX_SPRITES
) (
	input wire                      clk,
	input wire                      rst_n,
	input wire                      line_start,
	input wire sprite_pkg::coord_t  line,
	input wire                      tall,
	input wire                      entry_valid,
	input wire sprite_pkg::coord_t  entry_y,
	input wire sprite_pkg::coord_t  entry_x,
	input wire sprite_pkg::coord_t  pix_x,
	input wire                      fetch_ready,
	output logic                    stall,
	output logic                    fetch_valid,
	output sprite_pkg::slot_t       fetch_slot,
	output sprite_pkg::oam_index_t  fetch_index
);
	import sprite_pkg::*;

	logic [MAX_SPRITES-1:0] match;
	oam_index_t             index_array [MAX_SPRITES];
	logic                   clear;
	slot_t                  clear_slot;

	sprite_load_if #(.MAX_SPRITES(MAX_SPRITES)) load_bus (.clk(clk));

	oam_scan #(.MAX_SPRITES(MAX_SPRITES)) u_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.line        (line),
		.tall        (tall),
		.entry_valid (entry_valid),
		.entry_y     (entry_y),
		.entry_x     (entry_x),
		.load        (load_bus.source)
	);

	sprite_x_store #(.MAX_SPRITES(MAX_SPRITES)) u_store (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.pix_x       (pix_x),
		.clear       (clear),
		.clear_slot  (clear_slot),
		.load        (load_bus.sink),
		.match       (match),
		.index_array (index_array)
	);

	sprite_fetch_select #(.MAX_SPRITES(MAX_SPRITES)) u_select (
		.clk         (clk),
		.rst_n       (rst_n),
		.match       (match),
		.index_array (index_array),
		.fetch_ready (fetch_ready),
		.stall       (stall),
		.fetch_valid (fetch_valid),
		.fetch_slot  (fetch_slot),
		.fetch_index (fetch_index),
		.clear       (clear),
		.clear_slot  (clear_slot)
	);

endmodule

`default_nettype wire

//--- dv/sprite_line_tb.sv
`default_nettype none

module sprite_line_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import sprite_pkg::*;

	localparam int     SLOTS      = 10;
	localparam int     CYCLE_NS   = 40;
	localparam int     CASE_LIMIT = 400; // Cycles allowed per case
	localparam coord_t LAST_X     = 8'd167;
	localparam coord_t PARK_X     = 8'd255; // Outside the swept range while scanning

	logic       clk;
	logic       rst_n;
	logic       line_start;
	coord_t     line;
	logic       tall;
	logic       entry_valid;
	coord_t     entry_y;
	coord_t     entry_x;
	coord_t     pix_x;
	logic       fetch_ready;
	logic       stall;
	logic       fetch_valid;
	slot_t      fetch_slot;
	oam_index_t fetch_index;

	// Cases file contents, one element per case
	int c_line[$];
	int c_tall[$];
	int c_count[$];
	int c_mask[$];
	int c_rand[$];
	int c_sweep[$];
	int c_expect[$];
	int c_first[$];
	// OAM entries of all cases back to back
	int e_y[$];
	int e_x[$];
	int   n_cases;
	logic loaded;

	slot_t      exp_slot[$]; // Expected fetches of the current line, in order
	oam_index_t exp_index[$];

	logic [7:0] ready_mask;
	logic [2:0] ready_phase;
	logic       rand_gaps;
	logic       held;
	slot_t      held_slot;
	oam_index_t held_index;
	logic       pending;

	sprite_line_top #(.MAX_SPRITES(SLOTS)) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.line        (line),
		.tall        (tall),
		.entry_valid (entry_valid),
		.entry_y     (entry_y),
		.entry_x     (entry_x),
		.pix_x       (pix_x),
		.fetch_ready (fetch_ready),
		.stall       (stall),
		.fetch_valid (fetch_valid),
		.fetch_slot  (fetch_slot),
		.fetch_index (fetch_index)
	);

	always #(CYCLE_NS / 2) clk = ~clk;

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped after an error");
	endtask

	task automatic check_slot(slot_t got, slot_t exp, string what);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_index(oam_index_t got, oam_index_t exp, string what);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic load_cases();
		int    fd;
		int    n;
		int    ln;
		int    tl;
		int    cnt;
		int    msk;
		int    rnd;
		int    swp;
		int    exq;
		int    y;
		int    x;
		int    last;
		string text;
		fd = $fopen("dv/sprite_line_cases.txt", "r");
		if (fd == 0)
			abort_run("Cannot open dv/sprite_line_cases.txt");
		while ($fgets(text, fd) > 0) begin
			if (text.getc(0) == "C") begin
				n = $sscanf(text, "C %d %d %d %h %d %d %d", ln, tl, cnt, msk, rnd, swp, exq);
				if (n != 7 || cnt > 40 || msk == 0)
					abort_run({"Bad case line in the cases file: ", text});
				c_line.push_back(ln);
				c_tall.push_back(tl);
				c_count.push_back(cnt);
				c_mask.push_back(msk);
				c_rand.push_back(rnd);
				c_sweep.push_back(swp);
				c_expect.push_back(exq);
				c_first.push_back(e_y.size());
			end else if (text.getc(0) == "E") begin
				n = $sscanf(text, "E %d %d", y, x);
				if (n != 2 || c_first.size() == 0)
					abort_run({"Bad entry line in the cases file: ", text});
				e_y.push_back(y);
				e_x.push_back(x);
			end
		end
		$fclose(fd);
		n_cases = c_line.size();
		if (n_cases == 0)
			abort_run("The cases file holds no cases");
		for (int k = 0; k < n_cases; k++) begin
			last = (k + 1 < n_cases) ? c_first[k + 1] : e_y.size();
			if (last - c_first[k] != c_count[k])
				abort_run($sformatf("Case %0d lists a wrong number of entries", k));
		end
		loaded = 1'b1;
	endtask

	// Expected fetch order from the line-range, ten-slot and X-order rules
	task automatic build_model(int k);
		int h;
		int y;
		int used;
		int slot_x   [SLOTS];
		int slot_idx [SLOTS];
		exp_slot.delete();
		exp_index.delete();
		h    = (c_tall[k] != 0) ? 16 : 8;
		used = 0;
		for (int i = 0; i < c_count[k]; i++) begin
			y = e_y[c_first[k] + i];
			if (used < SLOTS && c_line[k] >= y && c_line[k] < y + h) begin
				slot_x[used]   = e_x[c_first[k] + i];
				slot_idx[used] = i;
				used++;
			end
		end
		for (int px = 0; px <= int'(LAST_X); px++) begin
			for (int s = 0; s < used; s++) begin
				if (slot_x[s] == px) begin
					exp_slot.push_back(slot_t'(s));
					exp_index.push_back(oam_index_t'(slot_idx[s]));
				end
			end
		end
		if (exp_slot.size() != c_expect[k])
			abort_run($sformatf("Case %0d: the cases file expects %0d fetches, the model finds %0d",
				k, c_expect[k], exp_slot.size()));
	endtask

	function automatic logic pick_ready();
		logic r;
		r           = ready_mask[ready_phase];
		ready_phase = ready_phase + 3'd1;
		if (rand_gaps && ($urandom % 4 == 0))
			r = 1'b0; // Extra gap
		return r;
	endfunction

	// Sampled at the falling edge, between the driving edges
	task automatic observe();
		if (pending)
			check_flag(fetch_valid, 1'b1, "fetch_valid one cycle after a match");
		if (held) begin
			check_flag(fetch_valid, 1'b1, "fetch_valid under back-pressure");
			check_slot(fetch_slot, held_slot, "fetch_slot under back-pressure");
			check_index(fetch_index, held_index, "fetch_index under back-pressure");
		end
		if (fetch_valid)
			check_flag(stall, 1'b1, "stall while a fetch is open");
		if (fetch_valid && fetch_ready) begin
			if (exp_slot.size() == 0)
				abort_run($sformatf("FAIL at %0d ns: fetch of slot %0d index %0d was not expected",
					$time, fetch_slot, fetch_index));
			check_slot(fetch_slot, exp_slot.pop_front(), "fetch_slot");
			check_index(fetch_index, exp_index.pop_front(), "fetch_index");
			held = 1'b0;
		end else begin
			held       = fetch_valid;
			held_slot  = fetch_slot;
			held_index = fetch_index;
		end
		pending = stall && !fetch_valid; // Stall with no open fetch means a match
	endtask

	task automatic cycle(output logic st);
		@(negedge clk);
		observe();
		st = stall;
		@(posedge clk);
		fetch_ready <= pick_ready();
	endtask

	task automatic idle_sweep();
		for (int px = 0; px <= int'(LAST_X); px++) begin
			pix_x <= coord_t'(px);
			@(negedge clk);
			check_flag(stall, 1'b0, "stall before any scan");
			check_flag(fetch_valid, 1'b0, "fetch_valid before any scan");
			@(posedge clk);
		end
	endtask

	task automatic sweep_line();
		logic st;
		logic done;
		done = 1'b0;
		pix_x <= '0;
		while (!done) begin
			cycle(st);
			if (!st) begin
				if (pix_x == LAST_X)
					done = 1'b1;
				else
					pix_x <= pix_x + 8'd1;
			end
		end
	endtask

	task automatic run_case(int k);
		logic st;
		int   first;
		first      = c_first[k];
		ready_mask = 8'(c_mask[k]);
		rand_gaps  = (c_rand[k] != 0);
		if (c_sweep[k] != 0) begin
			build_model(k);
		end else begin
			exp_slot.delete();
			exp_index.delete();
		end
		line       <= coord_t'(c_line[k]);
		tall       <= (c_tall[k] != 0);
		pix_x      <= PARK_X;
		line_start <= 1'b1;
		cycle(st);
		line_start <= 1'b0;
		for (int i = 0; i < c_count[k]; i++) begin
			entry_valid <= 1'b1;
			entry_y     <= coord_t'(e_y[first + i]);
			entry_x     <= coord_t'(e_x[first + i]);
			cycle(st);
		end
		entry_valid <= 1'b0;
		if (c_sweep[k] != 0) begin
			sweep_line();
			if (exp_slot.size() != 0)
				abort_run($sformatf("FAIL at %0d ns: case %0d ended with %0d fetches missing",
					$time, k, exp_slot.size()));
		end
	endtask

	initial begin
		wait (loaded);
		#(longint'(n_cases + 1) * CASE_LIMIT * CYCLE_NS);
		abort_run($sformatf("Timeout: the run did not finish within %0d blocks of %0d cycles",
			n_cases + 1, CASE_LIMIT));
	end

	initial begin
		int unsigned seed;
		clk         = 1'b0;
		rst_n       = 1'b0;
		line_start  = 1'b0;
		line        = '0;
		tall        = 1'b0;
		entry_valid = 1'b0;
		entry_y     = '0;
		entry_x     = '0;
		pix_x       = PARK_X;
		fetch_ready = 1'b0;
		loaded      = 1'b0;
		ready_mask  = 8'hff;
		ready_phase = '0;
		rand_gaps   = 1'b0;
		held        = 1'b0;
		held_slot   = '0;
		held_index  = '0;
		pending     = 1'b0;
		seed        = $urandom(29293);
		load_cases();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		idle_sweep();
		for (int k = 0; k < n_cases; k++)
			run_case(k);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/sprite_line_cases.txt
# C line tall entries ready_mask(hex) random_gaps sweep expected_fetches
# E y x, one line per OAM entry in index order, following its C line
# 8-row sprites, first and last rows of the range
C 50 0 5 ff 0 1 3
E 43 10
E 42 20
E 50 30
E 51 40
E 47 5
# 16-row sprites, first and last rows of the range
C 50 1 5 ff 0 1 3
E 35 12
E 34 22
E 50 8
E 51 16
E 42 100
# Eleven sprites on the line, only the first ten are kept
C 20 0 12 55 0 1 10
E 15 90
E 15 80
E 15 70
E 100 60
E 18 60
E 13 50
E 20 40
E 15 30
E 15 20
E 15 10
E 15 167
E 15 3
# Equal X, fetched in slot order
C 100 0 6 ff 0 1 5
E 96 64
E 96 65
E 96 64
E 90 64
E 97 64
E 96 65
# Random back-pressure on tall sprites
C 120 1 7 b5 1 1 5
E 110 30
E 105 30
E 104 50
E 120 0
E 115 99
E 119 30
E 121 5
# Line cut short, its sprites must not reach the next line
C 60 0 3 ff 0 0 0
E 55 12
E 58 70
E 60 140
C 61 0 3 ff 0 1 1
E 10 12
E 54 140
E 53 70

//--- flist.f
rtl/sprite_pkg.sv
rtl/sprite_load_if.sv
rtl/oam_scan.sv
rtl/sprite_x_store.sv
rtl/sprite_fetch_select.sv
rtl/sprite_line_top.sv
dv/sprite_line_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module sprite_line_tb \
	-f flist.f \
	-o sprite_line_sim &&
./obj_dir/sprite_line_sim ||
{ echo "Simulation run failed"; exit 1; }
